/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import mips_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result,
	output logic    overflow
);

	word_t sum;
	word_t diff;
	logic  lt;

	assign sum  = a + b;
	assign diff = a - b;
	assign lt   = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_ADD: result = sum;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SRL: result = b >> a[4:0]; // shift amount in a
			ALU_SUB: result = diff;
			ALU_SLT: result = {31'b0, lt};
			default: result = '0;
		endcase
	end

	////////////////////////////////////////
	// signed overflow, add and sub only
	////////////////////////////////////////
	always_comb begin
		case (op)
			ALU_ADD: overflow = (a[31] == b[31]) && (sum[31] != a[31]);
			ALU_SUB: overflow = (a[31] != b[31]) && (diff[31] != a[31]);
			default: overflow = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* design/cp0.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0 import mips_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	ctrl_if.cop   cop,
	input  word_t pc,
	input  logic  alu_ovf,
	input  word_t wdata,
	output word_t rdata,
	output word_t epc,
	output logic  exc
);

	word_t      epc_q;
	word_t      cause_q;
	logic [4:0] exc_code;
	word_t      rd_sel;

	assign exc = cop.syscall | cop.unknown | (alu_ovf & cop.ovf_check);

	always_comb begin
		if (cop.syscall) begin
			exc_code = EXC_SYSCALL;
		end else if (cop.unknown) begin
			exc_code = EXC_RI;
		end else begin
			exc_code = EXC_OV;
		end
	end

	////////////////////////////////////////
	// epc and cause registers
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			epc_q   <= '0;
			cause_q <= '0;
		end else if (exc) begin
			epc_q   <= pc;                       // faulting instruction
			cause_q <= {25'b0, exc_code, 2'b00}; // code in bits 6:2
		end else if (cop.cp0_we) begin
			case (cop.cp0_reg)
				CP0_EPC:   epc_q   <= wdata;
				CP0_CAUSE: cause_q <= wdata;
				default:   epc_q   <= epc_q;     // no such register
			endcase
		end
	end

	always_comb begin
		case (cop.cp0_reg)
			CP0_EPC:   rd_sel = epc_q;
			CP0_CAUSE: rd_sel = cause_q;
			default:   rd_sel = '0;
		endcase
	end

	assign rdata = cop.mfc0 ? rd_sel : '0;
	assign epc   = epc_q; // eret target

endmodule

`default_nettype wire

/* design/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if import mips_pkg::*; ();

	alu_op_t  alu_op;
	logic     sign_ext;  // sign extend imm16
	logic     src_imm;   // alu b from immediate
	logic     shamt_a;   // alu a from shamt
	logic     lui;
	logic     link;      // write pc+4
	logic     mem_we;
	logic     mem_to_reg;
	reg_idx_t dest;
	logic     reg_we;
	logic     beq;
	logic     bne;
	logic     j;
	logic     jr;
	logic     syscall;
	logic     unknown;
	logic     ovf_check;
	logic     eret;
	logic     cp0_we;
	reg_idx_t cp0_reg;
	logic     mfc0;

	modport decoder (
		output alu_op, sign_ext, src_imm, shamt_a, lui, link, mem_we, mem_to_reg, dest, reg_we,
		output beq, bne, j, jr, syscall, unknown, ovf_check, eret, cp0_we, cp0_reg, mfc0
	);

	modport datapath (
		input alu_op, sign_ext, src_imm, shamt_a, lui, link, mem_we, mem_to_reg, dest, reg_we,
		input beq, bne, j, jr, syscall, unknown, ovf_check, eret, cp0_we, cp0_reg, mfc0
	);

	modport pcu (input beq, bne, j, jr, eret);

	modport cop (input syscall, unknown, ovf_check, eret, cp0_we, cp0_reg, mfc0);

endinterface

`default_nettype wire

/* design/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; #(
	parameter word_t RESET_PC   = 32'h0000_0000,
	parameter word_t EXC_VECTOR = 32'h0000_0180
) (
	input  logic  clk,
	input  logic  rst_n,
	output word_t imem_addr,
	input  word_t imem_data,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic  dmem_we,
	input  word_t dmem_rdata
);

	ctrl_if ctl ();

	reg_idx_t   rs;
	reg_idx_t   rt;
	logic [4:0] shamt;
	logic [15:0] imm16;

	word_t pc;
	word_t pc_plus4;
	word_t rs_val;
	word_t rt_val;
	word_t imm_ext;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	word_t cp0_rdata;
	word_t epc;
	word_t jtarget;
	word_t wb_data;
	logic  alu_ovf;
	logic  exc;
	logic  zero_eq;
	logic  reg_we;

	assign rs        = imem_data[25:21];
	assign rt        = imem_data[20:16];
	assign shamt     = imem_data[10:6];
	assign imm16     = imem_data[15:0];
	assign imem_addr = pc;
	assign jtarget   = {pc_plus4[31:28], imem_data[25:0], 2'b00};
	assign zero_eq   = (rs_val == rt_val);

	mips_decoder mips_decoder_inst (
		.inst (imem_data),
		.ctl  (ctl.decoder)
	);

	////////////////////////////////////////
	// operand selection
	////////////////////////////////////////
	assign imm_ext = ctl.sign_ext ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};

	always_comb begin
		if (ctl.lui) begin
			alu_a = '0;             // or with zero
			alu_b = {imm16, 16'b0};
		end else begin
			alu_a = ctl.shamt_a ? {27'b0, shamt} : rs_val;
			alu_b = ctl.src_imm ? imm_ext : rt_val;
		end
	end

	alu alu_inst (
		.op       (ctl.alu_op),
		.a        (alu_a),
		.b        (alu_b),
		.result   (alu_result),
		.overflow (alu_ovf)
	);

	////////////////////////////////////////
	// writeback and memory
	////////////////////////////////////////
	always_comb begin
		if (ctl.link) begin
			wb_data = pc_plus4;
		end else if (ctl.mem_to_reg) begin
			wb_data = dmem_rdata;
		end else if (ctl.mfc0) begin
			wb_data = cp0_rdata;
		end else begin
			wb_data = alu_result;
		end
	end

	assign reg_we     = ctl.reg_we & ~exc & rst_n; // faulting instr writes nothing
	assign dmem_we    = ctl.mem_we & ~exc & rst_n;
	assign dmem_addr  = alu_result;
	assign dmem_wdata = rt_val;

	reg_file reg_file_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_idx  (rs),
		.rb_idx  (rt),
		.ra_data (rs_val),
		.rb_data (rt_val),
		.we      (reg_we),
		.w_idx   (ctl.dest),
		.w_data  (wb_data)
	);

	cp0 cp0_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.cop     (ctl.cop),
		.pc      (pc),
		.alu_ovf (alu_ovf),
		.wdata   (rt_val),
		.rdata   (cp0_rdata),
		.epc     (epc),
		.exc     (exc)
	);

	pc_unit #(
		.RESET_PC   (RESET_PC),
		.EXC_VECTOR (EXC_VECTOR)
	) pc_unit_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.pcu      (ctl.pcu),
		.exc      (exc),
		.epc      (epc),
		.zero_eq  (zero_eq),
		.imm      (imm_ext),
		.jtarget  (jtarget),
		.rs_val   (rs_val),
		.pc       (pc),
		.pc_plus4 (pc_plus4)
	);

endmodule

`default_nettype wire

/* design/mips_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_decoder import mips_pkg::*; (
	input word_t   inst,
	ctrl_if.decoder ctl
);

	logic [5:0] op;
	reg_idx_t   rs;
	reg_idx_t   rt;
	reg_idx_t   rd;
	logic [5:0] fn;

	assign op = inst[31:26];
	assign rs = inst[25:21];
	assign rt = inst[20:16];
	assign rd = inst[15:11];
	assign fn = inst[5:0];

	always_comb begin
		ctl.alu_op     = ALU_AND;
		ctl.sign_ext   = 1'b0;
		ctl.src_imm    = 1'b0;
		ctl.shamt_a    = 1'b0;
		ctl.lui        = 1'b0;
		ctl.link       = 1'b0;
		ctl.mem_we     = 1'b0;
		ctl.mem_to_reg = 1'b0;
		ctl.dest       = '0;
		ctl.reg_we     = 1'b0;
		ctl.beq        = 1'b0;
		ctl.bne        = 1'b0;
		ctl.j          = 1'b0;
		ctl.jr         = 1'b0;
		ctl.syscall    = 1'b0;
		ctl.unknown    = 1'b0;
		ctl.ovf_check  = 1'b0;
		ctl.eret       = 1'b0;
		ctl.cp0_we     = 1'b0;
		ctl.cp0_reg    = '0;
		ctl.mfc0       = 1'b0;

		if (inst == '0) begin
			ctl.unknown = 1'b0; // nop, all writes off
		end else begin
			case (op)
				OP_RTYPE: begin
					ctl.dest   = rd;
					ctl.reg_we = 1'b1; // cleared below where no write
					case (fn)
						FN_ADD: begin
							ctl.alu_op    = ALU_ADD;
							ctl.ovf_check = 1'b1;
						end
						FN_ADDU: ctl.alu_op = ALU_ADD;
						FN_SUB: begin
							ctl.alu_op    = ALU_SUB;
							ctl.ovf_check = 1'b1;
						end
						FN_SUBU: ctl.alu_op = ALU_SUB;
						FN_SLT:  ctl.alu_op = ALU_SLT; // signed
						FN_AND:  ctl.alu_op = ALU_AND;
						FN_OR:   ctl.alu_op = ALU_OR;
						FN_XOR:  ctl.alu_op = ALU_XOR;
						FN_NOR:  ctl.alu_op = ALU_NOR;
						FN_SRL: begin
							ctl.alu_op  = ALU_SRL;
							ctl.shamt_a = 1'b1; // rt >> shamt
						end
						FN_JR: begin
							ctl.jr     = 1'b1;
							ctl.reg_we = 1'b0;
						end
						FN_JALR: begin
							ctl.jr   = 1'b1;
							ctl.link = 1'b1; // link into rd
						end
						FN_SYSCALL: begin
							ctl.syscall = 1'b1;
							ctl.reg_we  = 1'b0;
						end
						default: begin
							ctl.unknown = 1'b1;
							ctl.reg_we  = 1'b0;
						end
					endcase
				end
				OP_LW, OP_SW: begin
					ctl.alu_op     = ALU_ADD; // base + offset
					ctl.sign_ext   = 1'b1;
					ctl.src_imm    = 1'b1;
					ctl.dest       = rt;
					ctl.reg_we     = (op == OP_LW);
					ctl.mem_to_reg = (op == OP_LW);
					ctl.mem_we     = (op == OP_SW);
				end
				OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
					ctl.src_imm   = 1'b1;
					ctl.dest      = rt;
					ctl.reg_we    = 1'b1;
					ctl.sign_ext  = (op == OP_ADDI) || (op == OP_SLTI);
					ctl.ovf_check = (op == OP_ADDI);
					ctl.lui       = (op == OP_LUI);
					case (op)
						OP_ADDI: ctl.alu_op = ALU_ADD;
						OP_SLTI: ctl.alu_op = ALU_SLT;
						OP_ANDI: ctl.alu_op = ALU_AND;
						OP_XORI: ctl.alu_op = ALU_XOR;
						default: ctl.alu_op = ALU_OR; // ori and lui
					endcase
				end
				OP_BEQ, OP_BNE: begin
					ctl.sign_ext = 1'b1; // branch offset
					ctl.beq      = (op == OP_BEQ);
					ctl.bne      = (op == OP_BNE);
				end
				OP_J: ctl.j = 1'b1;
				OP_JAL: begin
					ctl.j      = 1'b1;
					ctl.link   = 1'b1;
					ctl.dest   = 5'd31; // ra
					ctl.reg_we = 1'b1;
				end
				OP_COP0: begin
					if (inst == INST_ERET) begin
						ctl.eret = 1'b1;
					end else if (rs == RS_MFC0 && inst[10:3] == '0) begin
						ctl.mfc0    = 1'b1;
						ctl.cp0_reg = rd;
						ctl.dest    = rt;
						ctl.reg_we  = 1'b1;
					end else if (rs == RS_MTC0 && inst[10:3] == '0) begin
						ctl.cp0_we  = 1'b1;
						ctl.cp0_reg = rd;
					end else begin
						ctl.unknown = 1'b1;
					end
				end
				default: ctl.unknown = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;    // data, instructions, addresses
	typedef logic [4:0]  reg_idx_t; // gpr or cp0 register number
	typedef logic [3:0]  alu_op_t;

	////////////////////////////////////////
	// alu operation codes
	////////////////////////////////////////
	localparam alu_op_t ALU_AND = 4'b0000;
	localparam alu_op_t ALU_OR  = 4'b0001;
	localparam alu_op_t ALU_ADD = 4'b0010;
	localparam alu_op_t ALU_XOR = 4'b0011;
	localparam alu_op_t ALU_NOR = 4'b0100;
	localparam alu_op_t ALU_SRL = 4'b0101;
	localparam alu_op_t ALU_SUB = 4'b0110;
	localparam alu_op_t ALU_SLT = 4'b0111;

	////////////////////////////////////////
	// opcodes and function codes
	////////////////////////////////////////
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_COP0  = 6'h10;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	localparam logic [5:0] FN_SRL     = 6'h02;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_JALR    = 6'h09;
	localparam logic [5:0] FN_SYSCALL = 6'h0c;
	localparam logic [5:0] FN_ADD     = 6'h20;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUB     = 6'h22;
	localparam logic [5:0] FN_SUBU    = 6'h23;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_XOR     = 6'h26;
	localparam logic [5:0] FN_NOR     = 6'h27;
	localparam logic [5:0] FN_SLT     = 6'h2a;

	// cop0 rs field, fixed eret encoding
	localparam reg_idx_t RS_MFC0   = 5'b00000;
	localparam reg_idx_t RS_MTC0   = 5'b00100;
	localparam word_t    INST_ERET = 32'h4200_0018;

	localparam reg_idx_t CP0_CAUSE = 5'd13;
	localparam reg_idx_t CP0_EPC   = 5'd14;

	localparam logic [4:0] EXC_SYSCALL = 5'd8;
	localparam logic [4:0] EXC_RI      = 5'd10;
	localparam logic [4:0] EXC_OV      = 5'd12;

endpackage

`default_nettype wire

/* design/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit import mips_pkg::*; #(
	parameter word_t RESET_PC   = 32'h0000_0000,
	parameter word_t EXC_VECTOR = 32'h0000_0180
) (
	input  logic  clk,
	input  logic  rst_n,
	ctrl_if.pcu   pcu,
	input  logic  exc,
	input  word_t epc,
	input  logic  zero_eq,
	input  word_t imm,
	input  word_t jtarget,
	input  word_t rs_val,
	output word_t pc,
	output word_t pc_plus4
);

	word_t next_pc;
	word_t br_target;
	logic  br_taken;

	assign pc_plus4  = pc + 32'd4;
	assign br_target = pc_plus4 + {imm[29:0], 2'b00}; // word offset
	assign br_taken  = (pcu.beq & zero_eq) | (pcu.bne & ~zero_eq);

	always_comb begin
		if (exc) begin
			next_pc = EXC_VECTOR;
		end else if (pcu.eret) begin
			next_pc = epc;
		end else if (pcu.jr) begin
			next_pc = rs_val;
		end else if (pcu.j) begin
			next_pc = jtarget;
		end else if (br_taken) begin
			next_pc = br_target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import mips_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t ra_idx,
	input  reg_idx_t rb_idx,
	output word_t    ra_data,
	output word_t    rb_data,
	input  logic     we,
	input  reg_idx_t w_idx,
	input  word_t    w_data
);

	word_t regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && w_idx != '0) begin // $zero stays zero
			regs[w_idx] <= w_data;
		end
	end

	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];

endmodule

`default_nettype wire

/* flist.f */
design/mips_pkg.sv
design/ctrl_if.sv
design/mips_decoder.sv
design/reg_file.sv
design/alu.sv
design/cp0.sv
design/pc_unit.sv
design/mips_core.sv
testbench/mips_core_assertions.sv
testbench/tb_mips_core.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module tb_mips_core -f flist.f -o tb_mips_core \
	&& ./obj_dir/tb_mips_core +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -q "Simulation completed successfully" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }

/* testbench/mips_core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core_assertions import mips_pkg::*; #(
	parameter word_t RESET_PC   = 32'h0000_0000,
	parameter word_t EXC_VECTOR = 32'h0000_0180
) (
	input logic     clk,
	input logic     rst_n,
	input word_t    pc,
	input logic     exc,
	input logic     dmem_we,
	input reg_idx_t rs,
	input reg_idx_t rt,
	input word_t    rs_val,
	input word_t    rt_val
);

	int assert_errs = 0; // read by the testbench at the end

	reset_no_store: assert property (@(posedge clk) !rst_n |-> !dmem_we)
		else begin
			$error("dmem_we high during reset");
			assert_errs++;
		end

	reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> pc == RESET_PC)
		else begin
			$error("pc not at reset address after reset");
			assert_errs++;
		end

	exc_vector: assert property (@(posedge clk) disable iff (!rst_n) exc |=> pc == EXC_VECTOR)
		else begin
			$error("exception did not redirect to the vector");
			assert_errs++;
		end

	////////////////////////////////////////
	// $zero on both read ports
	////////////////////////////////////////
	zero_rs: assert property (@(posedge clk) disable iff (!rst_n) rs == '0 |-> rs_val == '0)
		else begin
			$error("register 0 read nonzero on port a");
			assert_errs++;
		end

	zero_rt: assert property (@(posedge clk) disable iff (!rst_n) rt == '0 |-> rt_val == '0)
		else begin
			$error("register 0 read nonzero on port b");
			assert_errs++;
		end

endmodule

bind mips_core mips_core_assertions #(
	.RESET_PC   (RESET_PC),
	.EXC_VECTOR (EXC_VECTOR)
) assertions_inst (
	.clk     (clk),
	.rst_n   (rst_n),
	.pc      (pc),
	.exc     (exc),
	.dmem_we (dmem_we),
	.rs      (rs),
	.rt      (rt),
	.rs_val  (rs_val),
	.rt_val  (rt_val)
);

`default_nettype wire

/* testbench/tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

	localparam word_t RESET_PC   = 32'h0000_0000;
	localparam word_t EXC_VECTOR = 32'h0000_0180;
	localparam int    MAX_CYCLES = 600; // about five times the program run

	logic  clk;
	logic  rst_n;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic  dmem_we;
	word_t dmem_rdata;

	word_t imem [256];
	word_t dmem [256];
	word_t exp_val [$];  // predicted stores, in program order
	word_t exp_addr [$];
	string exp_name [$];
	int    wp;           // next instruction word
	int    store_n;      // next result slot
	int    pass_cnt;
	int    fail_cnt;
	int    cycles;
	word_t end_pc;

	mips_core #(
		.RESET_PC   (RESET_PC),
		.EXC_VECTOR (EXC_VECTOR)
	) mips_core_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata)
	);

	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////
	// assembler helpers
	////////////////////////////////////////
	function automatic word_t r_inst(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
			reg_idx_t rd, logic [4:0] sh, logic [5:0] fn);
		return {op, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t i_inst(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_inst(logic [5:0] op, word_t target);
		return {op, target[27:2]};
	endfunction

	function automatic word_t sext16(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word_t here(); // byte address of next word
		return {wp[29:0], 2'b00};
	endfunction

	task automatic emit(word_t inst);
		imem[wp[7:0]] = inst;
		wp++;
	endtask

	task automatic expect_store(string name, word_t addr, word_t v);
		exp_val.push_back(v);
		exp_addr.push_back(addr);
		exp_name.push_back(name);
	endtask

	task automatic store_result(string name, reg_idx_t r, word_t v);
		logic [15:0] off;
		off = 16'h0200 + {6'b0, store_n[7:0], 2'b00};
		emit(i_inst(OP_SW, 5'd0, r, off));
		store_n++;
		expect_store(name, sext16(off), v); // base is $zero
	endtask

	task automatic load_word(reg_idx_t r, word_t v);
		emit(i_inst(OP_LUI, 5'd0, r, v[31:16]));
		emit(i_inst(OP_ORI, r, r, v[15:0]));
	endtask

	task automatic rtype_test(string name, logic [5:0] fn, reg_idx_t rs, reg_idx_t rt, word_t v);
		emit(r_inst(OP_RTYPE, rs, rt, 5'd5, 5'd0, fn));
		store_result(name, 5'd5, v);
	endtask

	task automatic itype_test(string name, logic [5:0] op, reg_idx_t rs, logic [15:0] imm,
			word_t v);
		emit(i_inst(op, rs, 5'd5, imm));
		store_result(name, 5'd5, v);
	endtask

	// r8 ends up good only if the branch went the predicted way
	task automatic branch_test(string name, logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
			logic taken, logic [15:0] good);
		emit(i_inst(OP_ORI, 5'd0, 5'd8, taken ? good : 16'hbad0));
		emit(i_inst(op, rs, rt, 16'd1));
		emit(i_inst(OP_ORI, 5'd0, 5'd8, taken ? 16'hbad0 : good));
		store_result(name, 5'd8, {16'b0, good});
	endtask

	task automatic build_program();
		word_t       a;
		word_t       b;
		word_t       c;
		word_t       d;
		word_t       e;
		word_t       at;
		logic [15:0] imm;
		logic [4:0]  sh;
		a = $urandom();
		b = $urandom();
		while (b == a) begin
			b = $urandom();
		end
		c = $urandom();
		c[31:30] = {2{c[29]}}; // small signed, add/sub cannot overflow
		d = $urandom();
		d[31:30] = {2{d[29]}};
		e = $urandom();
		store_result("reset_store", 5'd0, 32'h0); // fetched all through reset
		load_word(5'd1, a);
		load_word(5'd2, b);
		load_word(5'd3, c);
		load_word(5'd4, d);

		rtype_test("add", FN_ADD, 5'd3, 5'd4, c + d);
		rtype_test("addu", FN_ADDU, 5'd1, 5'd2, a + b);
		rtype_test("sub", FN_SUB, 5'd3, 5'd4, c - d);
		rtype_test("subu", FN_SUBU, 5'd1, 5'd2, a - b);
		rtype_test("slt", FN_SLT, 5'd1, 5'd2, {31'b0, $signed(a) < $signed(b)});
		rtype_test("and", FN_AND, 5'd1, 5'd2, a & b);
		rtype_test("or", FN_OR, 5'd1, 5'd2, a | b);
		rtype_test("xor", FN_XOR, 5'd1, 5'd2, a ^ b);
		rtype_test("nor", FN_NOR, 5'd1, 5'd2, ~(a | b));
		sh = 5'($urandom());
		emit(r_inst(OP_RTYPE, 5'd0, 5'd1, 5'd5, sh, FN_SRL));
		store_result("srl", 5'd5, a >> sh);
		imm = 16'($urandom());
		itype_test("addi", OP_ADDI, 5'd3, imm, c + sext16(imm));
		imm = 16'($urandom());
		itype_test("andi", OP_ANDI, 5'd1, imm, a & {16'b0, imm});
		imm = 16'($urandom());
		itype_test("ori", OP_ORI, 5'd1, imm, a | {16'b0, imm});
		imm = 16'($urandom());
		itype_test("xori", OP_XORI, 5'd1, imm, a ^ {16'b0, imm});
		imm = 16'($urandom());
		itype_test("slti", OP_SLTI, 5'd1, imm, {31'b0, $signed(a) < $signed(sext16(imm))});
		imm = 16'($urandom());
		itype_test("lui", OP_LUI, 5'd0, imm, {imm, 16'b0});

		////////////////////////////////////////
		// memory and register zero
		////////////////////////////////////////
		load_word(5'd6, e);
		emit(i_inst(OP_SW, 5'd0, 5'd6, 16'h01f0));
		expect_store("sw_word", 32'h0000_01f0, e);
		emit(i_inst(OP_LW, 5'd0, 5'd7, 16'h01f0));
		store_result("lw_word", 5'd7, e);
		emit(i_inst(OP_ORI, 5'd1, 5'd0, 16'h5a5a));
		store_result("r0_write", 5'd0, 32'h0);

		branch_test("beq_taken", OP_BEQ, 5'd1, 5'd1, 1'b1, 16'h1111);
		branch_test("beq_not_taken", OP_BEQ, 5'd1, 5'd2, 1'b0, 16'h1112);
		branch_test("bne_taken", OP_BNE, 5'd1, 5'd2, 1'b1, 16'h2221);
		branch_test("bne_not_taken", OP_BNE, 5'd1, 5'd1, 1'b0, 16'h2222);
		emit(i_inst(OP_ORI, 5'd0, 5'd8, 16'h3333));
		emit(j_inst(OP_J, here() + 32'd8));
		emit(i_inst(OP_ORI, 5'd0, 5'd8, 16'hbad0));
		store_result("j", 5'd8, 32'h3333);
		at = here() + 32'd16; // the sw after the skipped word
		emit(i_inst(OP_ORI, 5'd0, 5'd9, at[15:0]));
		emit(i_inst(OP_ORI, 5'd0, 5'd8, 16'h4444));
		emit(r_inst(OP_RTYPE, 5'd9, 5'd0, 5'd0, 5'd0, FN_JR));
		emit(i_inst(OP_ORI, 5'd0, 5'd8, 16'hbad0));
		store_result("jr", 5'd8, 32'h4444);

		at = here();
		emit(j_inst(OP_JAL, at + 32'd8));
		emit(i_inst(OP_ORI, 5'd0, 5'd8, 16'hbad0));
		store_result("jal_link", 5'd31, at + 32'd4);
		at = here() + 32'd12;
		emit(i_inst(OP_ORI, 5'd0, 5'd9, at[15:0]));
		at = here();
		emit(r_inst(OP_RTYPE, 5'd9, 5'd0, 5'd10, 5'd0, FN_JALR));
		emit(i_inst(OP_ORI, 5'd0, 5'd8, 16'hbad0));
		store_result("jalr_link", 5'd10, at + 32'd4);

		////////////////////////////////////////
		// exceptions, handler stores epc then cause
		////////////////////////////////////////
		at = here();
		emit(r_inst(OP_RTYPE, 5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL));
		expect_store("syscall_epc", 32'h0000_01e0, at);
		expect_store("syscall_cause", 32'h0000_01e4, {25'b0, EXC_SYSCALL, 2'b00});
		at = here();
		emit(i_inst(6'h3f, 5'd0, 5'd0, 16'h0)); // no such opcode
		expect_store("unknown_epc", 32'h0000_01e0, at);
		expect_store("unknown_cause", 32'h0000_01e4, {25'b0, EXC_RI, 2'b00});
		load_word(5'd11, 32'h7fff_ffff);
		emit(i_inst(OP_ORI, 5'd0, 5'd12, 16'h0001));
		emit(i_inst(OP_ORI, 5'd0, 5'd13, 16'h5555));
		at = here();
		emit(r_inst(OP_RTYPE, 5'd11, 5'd12, 5'd13, 5'd0, FN_ADD));
		expect_store("ovf_epc", 32'h0000_01e0, at);
		expect_store("ovf_cause", 32'h0000_01e4, {25'b0, EXC_OV, 2'b00});
		store_result("ovf_no_write", 5'd13, 32'h5555);
		end_pc = here();
		emit(j_inst(OP_J, end_pc)); // end marker, spins here

		wp = int'(EXC_VECTOR >> 2);
		emit(r_inst(OP_COP0, RS_MFC0, 5'd20, CP0_EPC, 5'd0, 6'h00));
		emit(r_inst(OP_COP0, RS_MFC0, 5'd21, CP0_CAUSE, 5'd0, 6'h00));
		emit(i_inst(OP_SW, 5'd0, 5'd20, 16'h01e0));
		emit(i_inst(OP_SW, 5'd0, 5'd21, 16'h01e4));
		emit(i_inst(OP_ADDI, 5'd20, 5'd20, 16'd4));
		emit(r_inst(OP_COP0, RS_MTC0, 5'd20, CP0_EPC, 5'd0, 6'h00));
		emit(r_inst(OP_COP0, 5'h10, 5'd0, 5'd0, 5'd0, 6'h18)); // eret
	endtask

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	// stores checked mid-cycle
	always @(negedge clk) begin
		if (rst_n && dmem_we) begin
			if (exp_val.size() == 0) begin
				$display("store of %h to %h was not expected", dmem_wdata, dmem_addr);
				fail_cnt++;
			end else begin
				if (dmem_addr !== exp_addr[0]) begin
					$display("FAIL %s address expected %h actual %h", exp_name[0],
						exp_addr[0], dmem_addr);
					fail_cnt++;
				end else if (dmem_wdata === exp_val[0]) begin
					$display("PASS %s value %h", exp_name[0], dmem_wdata);
					pass_cnt++;
				end else begin
					$display("FAIL %s expected %h actual %h", exp_name[0], exp_val[0],
						dmem_wdata);
					fail_cnt++;
				end
				void'(exp_val.pop_front());
				void'(exp_addr.pop_front());
				void'(exp_name.pop_front());
			end
		end
	end

	initial begin
		void'($urandom(31124));
		rst_n    = 1'b0;
		wp       = 0;
		store_n  = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		cycles   = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] = j_inst(OP_J, {22'b0, i[7:0], 2'b00}); // unused words spin
			dmem[i[7:0]] <= {24'hd00d00, i[7:0]};
		end
		build_program();
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;

		while (imem_addr !== end_pc && cycles < MAX_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (imem_addr !== end_pc) begin
			$display("timeout: program did not reach its end marker in %0d cycles", cycles);
			fail_cnt++;
		end else if (exp_val.size() != 0) begin
			$display("%0d expected stores never happened", exp_val.size());
			fail_cnt++;
		end
		if (mips_core_inst.assertions_inst.assert_errs != 0) begin
			$display("%0d assertion failures", mips_core_inst.assertions_inst.assert_errs);
			fail_cnt += mips_core_inst.assertions_inst.assert_errs;
		end
		$display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
